// File: mips_cpu_macros.svh
`ifndef MIPS_CPU_MACROS_SVH
`define MIPS_CPU_MACROS_SVH

`define MIPS_RESET_VECTOR 32'hBFC00000
`define MIPS_NUM_REGS     32
`define MIPS_V0           2

`endif

// File: mips_cpu_pkg.sv
package mips_cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        st_halted = 3'd0,
        st_fetch  = 3'd1,
        st_decode = 3'd2,
        st_exec1  = 3'd3,
        st_exec2  = 3'd4
    } cpu_state_t;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sb      = 6'h28,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_pass_b = 4'd6,
        alu_eq     = 4'd7,
        alu_ne     = 4'd8
    } alu_op_t;

    typedef struct packed {
        logic       regdst;       // 1 selects rd
        logic       regwrite;
        logic       memtoreg;
        logic       iord;         // Data address instead of pc
        logic       irwrite;
        logic       pcwrite;
        logic       pcwritecond;
        logic [1:0] pcsource;     // pc+4, branch target, jump target, rs
        logic       jump;
        logic       memread;
        logic       memwrite;
        logic [3:0] byteenable;
        alu_op_t    aluop;
        logic       alusrca;      // 0 pc, 1 rs
        logic [1:0] alusrcb;      // rt, 4, sign ext, zero ext
        logic       lui_sel;
        logic       is_load_tail; // Load data valid this cycle
    } ctrl_t;

endpackage

// File: mips_cpu_sequencer.sv
`timescale 1ns/1ns

module mips_cpu_sequencer
    import mips_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       waitrequest,
    input  ctrl_t      ctrl,
    input  logic       pc_is_zero,
    output cpu_state_t state,
    output logic       active
);

    logic mem_busy;

    assign mem_busy = (ctrl.memread || ctrl.memwrite) && waitrequest;
    assign active   = (state != st_halted);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            case (state)
                st_fetch: begin
                    if (!mem_busy) begin
                        state <= st_decode;
                    end
                end
                st_decode: state <= st_exec1;
                st_exec1: begin
                    if (mem_busy) begin
                        state <= st_exec1;  // Bus stall
                    end else if (ctrl.is_load_tail) begin
                        state <= st_exec2;
                    end else if (ctrl.jump && pc_is_zero) begin
                        state <= st_halted;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_exec2: state <= st_fetch;
                default: state <= st_halted;
            endcase
        end
    end

endmodule

// File: mips_cpu_controller.sv
`timescale 1ns/1ns

module mips_cpu_controller
    import mips_cpu_pkg::*;
(
    input  word_t      instr,
    input  logic [1:0] addr_low,
    input  cpu_state_t state,
    input  logic       waitrequest,
    output ctrl_t      ctrl
);

    opcode_t op;
    funct_t  funct;
    logic    is_mem;

    assign op     = opcode_t'(instr[31:26]);
    assign funct  = instr[5:0];
    assign is_mem = (op == op_lw) || (op == op_sw) || (op == op_sb);

    always_comb begin
        ctrl = '0;
        case (state)
            st_fetch: begin
                ctrl.memread    = 1'b1;
                ctrl.byteenable = 4'b1111;
                ctrl.irwrite    = !waitrequest;
                ctrl.pcwrite    = !waitrequest;
                ctrl.alusrcb    = 2'd1;  // pc + 4
            end
            st_decode: begin
                // Memory ops form their address, others the branch target
                ctrl.alusrca = is_mem;
                ctrl.alusrcb = 2'd2;
            end
            st_exec1: begin
                case (op)
                    op_special: begin
                        case (funct)
                            6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a: begin
                                ctrl.regdst   = 1'b1;
                                ctrl.regwrite = 1'b1;
                                ctrl.alusrca  = 1'b1;
                                case (funct)
                                    6'h23:   ctrl.aluop = alu_sub;
                                    6'h24:   ctrl.aluop = alu_and;
                                    6'h25:   ctrl.aluop = alu_or;
                                    6'h26:   ctrl.aluop = alu_xor;
                                    6'h2a:   ctrl.aluop = alu_slt;
                                    default: ctrl.aluop = alu_add;
                                endcase
                            end
                            6'h08: begin  // JR
                                ctrl.jump     = 1'b1;
                                ctrl.pcsource = 2'd3;
                                ctrl.aluop    = alu_pass_b;
                            end
                            default: ;
                        endcase
                    end
                    op_addiu: begin
                        ctrl.regwrite = 1'b1;
                        ctrl.alusrca  = 1'b1;
                        ctrl.alusrcb  = 2'd2;
                    end
                    op_ori: begin
                        ctrl.regwrite = 1'b1;
                        ctrl.alusrca  = 1'b1;
                        ctrl.alusrcb  = 2'd3;
                        ctrl.aluop    = alu_or;
                    end
                    op_lui: begin
                        ctrl.regwrite = 1'b1;
                        ctrl.alusrcb  = 2'd3;
                        ctrl.aluop    = alu_pass_b;
                        ctrl.lui_sel  = 1'b1;
                    end
                    op_lw: begin
                        ctrl.iord         = 1'b1;
                        ctrl.memread      = 1'b1;
                        ctrl.byteenable   = 4'b1111;
                        ctrl.is_load_tail = !waitrequest;
                    end
                    op_sw, op_sb: begin
                        ctrl.iord       = 1'b1;
                        ctrl.memwrite   = 1'b1;
                        ctrl.byteenable = (op == op_sw) ? 4'b1111 : 4'b0001 << addr_low;
                    end
                    op_beq, op_bne: begin
                        ctrl.alusrca     = 1'b1;
                        ctrl.pcwritecond = 1'b1;
                        ctrl.pcsource    = 2'd1;
                        ctrl.aluop       = (op == op_beq) ? alu_eq : alu_ne;
                    end
                    op_j: begin
                        ctrl.jump     = 1'b1;
                        ctrl.pcsource = 2'd2;
                    end
                    default: ;  // Unknown opcode runs as a nop
                endcase
            end
            st_exec2: begin
                if (op == op_lw) begin
                    ctrl.regwrite = 1'b1;
                    ctrl.memtoreg = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: mips_cpu_instr_latch.sv
`timescale 1ns/1ns

module mips_cpu_instr_latch
    import mips_cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t readdata,
    input  ctrl_t ctrl,
    output word_t instr,
    output word_t mdr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
            mdr   <= '0;
        end else begin
            if (ctrl.irwrite && ctrl.memread && !ctrl.iord) begin
                instr <= readdata;
            end
            if (ctrl.is_load_tail && ctrl.memread && ctrl.iord) begin
                mdr <= readdata;  // Last cycle of the data read
            end
        end
    end

endmodule

// File: mips_cpu_regfile.sv
`timescale 1ns/1ns
`include "mips_cpu_macros.svh"

module mips_cpu_regfile
    import mips_cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra,
    input  reg_addr_t rb,
    input  reg_addr_t wa,
    input  word_t     wd,
    input  logic      we,
    output word_t     rda,
    output word_t     rdb,
    output word_t     register_v0
);

    word_t regs [`MIPS_NUM_REGS];

    assign rda         = (ra == '0) ? '0 : regs[ra];
    assign rdb         = (rb == '0) ? '0 : regs[rb];
    assign register_v0 = regs[`MIPS_V0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

// File: mips_cpu_alu.sv
`timescale 1ns/1ns

module mips_cpu_alu
    import mips_cpu_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    cond
);

    always_comb begin
        case (op)
            alu_eq:  cond = (a == b);
            alu_ne:  cond = (a != b);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            alu_add:        result = a + b;
            alu_sub:        result = a - b;
            alu_and:        result = a & b;
            alu_or:         result = a | b;
            alu_xor:        result = a ^ b;
            alu_slt:        result = {31'b0, $signed(a) < $signed(b)};
            alu_pass_b:     result = b;
            alu_eq, alu_ne: result = {31'b0, cond};
            default:        result = '0;
        endcase
    end

endmodule

// File: mips_cpu_datapath.sv
`timescale 1ns/1ns
`include "mips_cpu_macros.svh"

module mips_cpu_datapath
    import mips_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  cpu_state_t state,
    input  ctrl_t      ctrl,
    input  word_t      instr,
    input  word_t      mdr,
    output word_t      pc,
    output word_t      alu_out,
    output word_t      b_reg,
    output word_t      register_v0,
    output logic       pc_is_zero
);

    word_t     a_reg;
    word_t     rda;
    word_t     rdb;
    word_t     wd;
    word_t     a_op;
    word_t     b_op;
    word_t     alu_result;
    word_t     imm_sext;
    word_t     imm_zext;
    word_t     pc_next;
    reg_addr_t wa;
    logic      cond;

    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0, instr[15:0]};
    assign wa       = ctrl.regdst ? instr[15:11] : instr[20:16];

    assign wd = ctrl.memtoreg ? mdr :
                ctrl.lui_sel  ? {alu_result[15:0], 16'h0} : alu_result;

    // Registers are read straight from the file while A is not yet loaded
    assign a_op = ctrl.alusrca ? ((state == st_decode) ? rda : a_reg) : pc;

    always_comb begin
        case (ctrl.alusrcb)
            2'd0:    b_op = b_reg;
            2'd1:    b_op = 32'd4;
            2'd2:    b_op = ctrl.alusrca ? imm_sext : {imm_sext[29:0], 2'b00};  // Word offset
            default: b_op = imm_zext;
        endcase
    end

    always_comb begin
        case (ctrl.pcsource)
            2'd0:    pc_next = alu_result;
            2'd1:    pc_next = alu_out;
            2'd2:    pc_next = {pc[31:28], instr[25:0], 2'b00};
            default: pc_next = a_reg;
        endcase
    end

    assign pc_is_zero = (pc_next == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (ctrl.pcwrite || ctrl.jump || (ctrl.pcwritecond && cond)) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            a_reg   <= rda;
            b_reg   <= rdb;
            alu_out <= alu_result;  // Branch target or data address
        end
    end

    mips_cpu_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .ra          (instr[25:21]),
        .rb          (instr[20:16]),
        .wa          (wa),
        .wd          (wd),
        .we          (ctrl.regwrite),
        .rda         (rda),
        .rdb         (rdb),
        .register_v0 (register_v0)
    );

    mips_cpu_alu u_alu (
        .op     (ctrl.aluop),
        .a      (a_op),
        .b      (b_op),
        .result (alu_result),
        .cond   (cond)
    );

endmodule

// File: mips_cpu_bus_port.sv
`timescale 1ns/1ns

module mips_cpu_bus_port
    import mips_cpu_pkg::*;
(
    input  ctrl_t      ctrl,
    input  word_t      pc,
    input  word_t      alu_out,
    input  word_t      b_reg,
    output word_t      address,
    output logic       read,
    output logic       write,
    output logic [3:0] byteenable,
    output word_t      writedata
);

    logic byte_store;

    assign byte_store = ctrl.memwrite && (ctrl.byteenable != 4'b1111);

    assign address    = ctrl.iord ? alu_out : pc;
    assign read       = ctrl.memread;
    assign write      = ctrl.memwrite;
    assign byteenable = ctrl.byteenable;

    // Byte copied to every lane so byteenable picks the lane that lands
    assign writedata = byte_store ? {4{b_reg[7:0]}} : b_reg;

endmodule

// File: mips_cpu_bus.sv
`timescale 1ns/1ns

module mips_cpu_bus
    import mips_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    cpu_state_t state;
    ctrl_t      ctrl;
    word_t      instr;
    word_t      mdr;
    word_t      pc;
    word_t      alu_out;
    word_t      b_reg;
    logic       pc_is_zero;

    mips_cpu_instr_latch u_instr_latch (
        .clk      (clk),
        .reset    (reset),
        .readdata (readdata),
        .ctrl     (ctrl),
        .instr    (instr),
        .mdr      (mdr)
    );

    mips_cpu_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .ctrl        (ctrl),
        .pc_is_zero  (pc_is_zero),
        .state       (state),
        .active      (active)
    );

    mips_cpu_controller u_controller (
        .instr       (instr),
        .addr_low    (alu_out[1:0]),
        .state       (state),
        .waitrequest (waitrequest),
        .ctrl        (ctrl)
    );

    mips_cpu_datapath u_datapath (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .ctrl        (ctrl),
        .instr       (instr),
        .mdr         (mdr),
        .pc          (pc),
        .alu_out     (alu_out),
        .b_reg       (b_reg),
        .register_v0 (register_v0),
        .pc_is_zero  (pc_is_zero)
    );

    mips_cpu_bus_port u_bus_port (
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_out    (alu_out),
        .b_reg      (b_reg),
        .address    (address),
        .read       (read),
        .write      (write),
        .byteenable (byteenable),
        .writedata  (writedata)
    );

endmodule

// File: mips_cpu_tb.sv
`timescale 1ns/1ns
`include "mips_cpu_macros.svh"

module mips_cpu_tb
    import mips_cpu_pkg::*;
();

    localparam int NUM_TESTS   = 6;
    localparam int MAX_INSTR   = 40;
    localparam int CLK_PERIOD  = 20;
    localparam int QUIET       = 20;
    localparam int WATCHDOG_NS = NUM_TESTS * (MAX_INSTR * 12 + QUIET + 10) * CLK_PERIOD;

    typedef struct packed {
        word_t      addr;
        word_t      data;
        logic [3:0] be;
    } store_t;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest = 1'b1;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata = '0;

    word_t  prog [64];
    word_t  dmem [64];        // Bus side data area at 0x100
    word_t  model_dmem [64];
    word_t  model_regs [32];
    word_t  salt;
    word_t  exp_trace [$];
    word_t  fetch_trace [$];
    store_t exp_stores [$];
    string  test_name;
    int     errors = 0;
    int     failed_tests = 0;
    logic   first_read_pending = 1'b0;

    mips_cpu_bus u_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    task automatic report_mismatch(string what, word_t expected, word_t actual);
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_error(string msg);
        $display("ERROR %s %s", test_name, msg);
        errors++;
    endtask

    function automatic logic in_prog(word_t a);
        word_t ofs;
        ofs = a - `MIPS_RESET_VECTOR;
        return ofs < 32'd256;
    endfunction

    function automatic logic in_data(word_t a);
        return a[31:8] == 24'h000001;
    endfunction

    function automatic word_t lane_mask(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic word_t fill_word(word_t a);
        return (a * 32'h9e3779b1) ^ salt;  // Mixes every address bit
    endfunction

    function automatic word_t bus_read(word_t a);
        word_t ofs;
        ofs = a - `MIPS_RESET_VECTOR;
        if (in_prog(a)) begin
            return prog[ofs[7:2]];
        end
        if (in_data(a)) begin
            return dmem[a[7:2]];
        end
        return '0;
    endfunction

    task automatic build_program();
        int          body;
        int          i;
        int          kind;
        int          tgt;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        funct_t      fn;
        word_t       jaddr;
        body = 20 + int'($urandom % 21);
        for (i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        for (i = 0; i < body; i++) begin
            rs    = reg_addr_t'($urandom);
            rt    = reg_addr_t'($urandom);
            rd    = reg_addr_t'($urandom);
            imm   = 16'($urandom);
            kind  = int'($urandom % 15);
            tgt   = i + 1 + int'($urandom % 32'(body - i));  // Forward up to the ADDU
            jaddr = `MIPS_RESET_VECTOR + 32'(4 * tgt);
            case (kind)
                0:       fn = 6'h21;
                1:       fn = 6'h23;
                2:       fn = 6'h24;
                3:       fn = 6'h25;
                4:       fn = 6'h26;
                default: fn = 6'h2a;
            endcase
            case (kind)
                0, 1, 2, 3, 4, 5: prog[i] = {op_special, rs, rt, rd, 5'd0, fn};
                6:       prog[i] = {op_addiu, rs, rt, imm};
                7:       prog[i] = {op_ori, rs, rt, imm};
                8:       prog[i] = {op_lui, 5'd0, rt, imm};
                9:       prog[i] = {op_lw, 5'd0, rt, 8'h01, imm[7:2], 2'b00};
                10:      prog[i] = {op_sw, 5'd0, rt, 8'h01, imm[7:2], 2'b00};
                11:      prog[i] = {op_sb, 5'd0, rt, 8'h01, imm[7:0]};
                12:      prog[i] = {op_beq, rs, rt, 16'(tgt - i - 1)};
                13:      prog[i] = {op_bne, rs, rt, 16'(tgt - i - 1)};
                default: prog[i] = {op_j, jaddr[27:2]};
            endcase
        end
        prog[body]     = {op_special, rs, rt, 5'd2, 5'd0, 6'h21};
        prog[body + 1] = {op_special, 5'd0, 5'd0, 5'd0, 5'd0, 6'h08};  // JR to zero
    endtask

    task automatic run_model();
        word_t     pc;
        word_t     ir;
        word_t     a;
        word_t     b;
        word_t     ea;
        word_t     res;
        word_t     ofs;
        reg_addr_t dst;
        logic      wr;
        logic      done;
        int        steps;
        store_t    st;
        for (steps = 0; steps < 32; steps++) begin
            model_regs[steps] = '0;
        end
        pc    = `MIPS_RESET_VECTOR;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 200) begin
            exp_trace.push_back(pc);
            ofs = pc - `MIPS_RESET_VECTOR;
            ir  = prog[ofs[7:2]];
            a   = model_regs[ir[25:21]];
            b   = model_regs[ir[20:16]];
            ea  = a + {{16{ir[15]}}, ir[15:0]};
            pc  = pc + 32'd4;
            res = '0;
            dst = ir[20:16];
            wr  = 1'b1;
            case (ir[31:26])
                op_special: begin
                    dst = ir[15:11];
                    case (ir[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = {31'b0, $signed(a) < $signed(b)};
                        default: begin  // JR
                            wr   = 1'b0;
                            pc   = a;
                            done = (a == '0);
                        end
                    endcase
                end
                op_addiu: res = ea;
                op_ori:   res = a | {16'h0, ir[15:0]};
                op_lui:   res = {ir[15:0], 16'h0};
                op_lw:    res = model_dmem[ea[7:2]];
                op_sw, op_sb: begin
                    wr      = 1'b0;
                    st.addr = ea;
                    st.be   = (ir[31:26] == op_sw) ? 4'hf : 4'b0001 << ea[1:0];
                    st.data = (ir[31:26] == op_sw) ? b : {24'h0, b[7:0]} << {ea[1:0], 3'b000};
                    model_dmem[ea[7:2]] = (model_dmem[ea[7:2]] & ~lane_mask(st.be))
                                        | (st.data & lane_mask(st.be));
                    exp_stores.push_back(st);
                end
                op_beq, op_bne: begin
                    wr = 1'b0;
                    if ((a == b) == (ir[31:26] == op_beq)) begin
                        pc = pc + {{14{ir[15]}}, ir[15:0], 2'b00};
                    end
                end
                op_j: begin
                    wr = 1'b0;
                    pc = {pc[31:28], ir[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                model_regs[dst] = res;
            end
            steps++;
        end
    endtask

    task automatic finish_transfer();
        store_t want;
        word_t  m;
        if (read && in_prog(address)) begin
            fetch_trace.push_back(address);
        end
        if (write) begin
            assert (exp_stores.size() != 0)
            else report_error($sformatf("unexpected bus write to %h", address));
            if (exp_stores.size() != 0) begin
                want = exp_stores.pop_front();
                m    = lane_mask(want.be);
                assert (address == want.addr)
                else report_mismatch("store address", want.addr, address);
                assert (byteenable == want.be)
                else report_mismatch("byteenable", {28'h0, want.be}, {28'h0, byteenable});
                assert ((writedata & m) == (want.data & m))
                else report_mismatch("store data", want.data & m, writedata & m);
            end
            m = lane_mask(byteenable);
            if (in_data(address)) begin
                dmem[address[7:2]] = (dmem[address[7:2]] & ~m) | (writedata & m);
            end else begin
                report_error($sformatf("bus write outside the data area at %h", address));
            end
        end
    endtask

    task automatic check_results();
        int i;
        assert (register_v0 == model_regs[`MIPS_V0])
        else report_mismatch("register_v0", model_regs[`MIPS_V0], register_v0);
        for (i = 0; i < 64; i++) begin
            assert (dmem[i] == model_dmem[i])
            else report_mismatch($sformatf("data word %0d", i), model_dmem[i], dmem[i]);
        end
        assert (exp_stores.size() == 0)
        else report_error($sformatf("%0d expected stores never reached the bus",
                                    exp_stores.size()));
        assert (fetch_trace.size() == exp_trace.size())
        else report_mismatch("fetch count", 32'(exp_trace.size()), 32'(fetch_trace.size()));
        for (i = 0; i < exp_trace.size() && i < fetch_trace.size(); i++) begin
            assert (fetch_trace[i] == exp_trace[i])
            else report_mismatch($sformatf("fetch %0d address", i), exp_trace[i], fetch_trace[i]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Slave side of the bus with 0 to 3 wait cycles per transfer
    initial begin
        int   wait_left;
        logic in_xfer;
        wait_left = 0;
        in_xfer   = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                waitrequest = 1'b1;
                in_xfer     = 1'b0;
            end else if (!(read || write)) begin
                waitrequest = 1'b0;
            end else begin
                if (!in_xfer) begin
                    in_xfer   = 1'b1;
                    wait_left = int'($urandom % 4);
                    if (first_read_pending) begin
                        assert (read && address == `MIPS_RESET_VECTOR)
                        else report_mismatch("first fetch address", `MIPS_RESET_VECTOR, address);
                        first_read_pending = 1'b0;
                    end
                end
                if (read) begin
                    readdata = bus_read(address);
                end
                if (wait_left > 0) begin
                    waitrequest = 1'b1;
                    wait_left--;
                end else begin
                    waitrequest = 1'b0;
                    in_xfer     = 1'b0;
                    finish_transfer();  // Completes on the coming rising edge
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the CPU did not halt", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int t;
        int i;
        int test_start;
        void'($urandom(32'hf8a02175));
        for (t = 0; t < NUM_TESTS; t++) begin
            test_name  = $sformatf("random_prog_%0d", t);
            test_start = errors;
            reset <= 1'b1;
            salt = $urandom;
            for (i = 0; i < 64; i++) begin
                dmem[i]       = fill_word(32'h100 + 32'(4 * i));
                model_dmem[i] = dmem[i];
            end
            fetch_trace.delete();
            exp_trace.delete();
            exp_stores.delete();
            build_program();
            run_model();
            first_read_pending = 1'b1;
            repeat (2) @(negedge clk);
            reset <= 1'b0;
            @(negedge clk);
            assert (active) else report_error("active is low after reset");
            while (active) begin
                @(negedge clk);
            end
            repeat (QUIET) begin
                @(negedge clk);
                assert (!read && !write) else report_error("bus access after halt");
            end
            check_results();
            if (errors == test_start) begin
                $display("%s: pass", test_name);
            end else begin
                failed_tests++;
                $display("%s: fail, %0d errors", test_name, errors - test_start);
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
mips_cpu_pkg.sv
mips_cpu_sequencer.sv
mips_cpu_controller.sv
mips_cpu_instr_latch.sv
mips_cpu_regfile.sv
mips_cpu_alu.sv
mips_cpu_datapath.sv
mips_cpu_bus_port.sv
mips_cpu_bus.sv
mips_cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --assert -j 0 --top-module mips_cpu_tb -f flist.f -o mips_cpu_tb_sim \
    && ./obj_dir/mips_cpu_tb_sim; } > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
